// File: logic/mmu_cfg_pkg.sv
/*
 * Sv39 translation scheme
 * field widths, page offset and level count
 * address, page number and ASID types
 */
package mmu_cfg_pkg;

  //////////////////////////////////////////////////
  // field widths
  //////////////////////////////////////////////////
  localparam int unsigned PageOffsetBits = 12;
  localparam int unsigned PtLevels       = 3;
  localparam int unsigned VpnPartBits    = 9;   // per page-table level
  localparam int unsigned VpnBits        = PtLevels * VpnPartBits;
  localparam int unsigned VaddrBits      = VpnBits + PageOffsetBits;
  localparam int unsigned PpnBits        = 44;
  localparam int unsigned AsidBits       = 16;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////
  typedef logic [VaddrBits-1:0]   vaddr_t;     // 39 bit virtual address
  typedef logic [VpnBits-1:0]     vpn_t;
  typedef logic [VpnPartBits-1:0] vpn_part_t;  // one level of the vpn
  typedef logic [PpnBits-1:0]     ppn_t;
  typedef logic [AsidBits-1:0]    asid_t;

endpackage

// File: logic/tlb_types_pkg.sv
/*
 * shared TLB data structures
 * PTE, superpage flags, stored tag,
 * registered lookup context and TLB update
 */
package tlb_types_pkg;

  // page-table entry, reserved and rsw bits not kept
  typedef struct packed {
    mmu_cfg_pkg::ppn_t ppn;
    logic              d;
    logic              a;
    logic              g;  // global, ignores asid
    logic              u;
    logic              x;
    logic              w;
    logic              r;
    logic              v;
  } pte_t;

  // bit 1 -> 1 GiB page, bit 0 -> 2 MiB page
  typedef logic [1:0] is_page_t;

  typedef struct packed {
    mmu_cfg_pkg::asid_t asid;
    mmu_cfg_pkg::vpn_t  vpn;
    is_page_t           is_page;
  } stlb_tag_t;

  typedef struct packed {
    logic               valid;
    logic               from_itlb;  // origin of the miss
    mmu_cfg_pkg::vpn_t  vpn;
    mmu_cfg_pkg::asid_t asid;
  } stlb_lookup_t;

  // refill from the walker and update towards the first-level TLBs
  typedef struct packed {
    logic               valid;
    mmu_cfg_pkg::vpn_t  vpn;
    mmu_cfg_pkg::asid_t asid;
    is_page_t           is_page;
    pte_t               content;
  } tlb_update_t;

endpackage

// File: logic/stlb_ram.sv
/*
 * single-port synchronous RAM
 * one word read or written per cycle
 */
`timescale 1ns/1ps

module stlb_ram #(
  parameter  int unsigned Width = 32,
  parameter  int unsigned Depth = 16,
  localparam int unsigned IdxW  = $clog2(Depth)
) (
  input  logic             clk_i,
  input  logic             req_i,
  input  logic             we_i,
  input  logic [IdxW-1:0]  addr_i,
  input  logic [Width-1:0] wdata_i,
  output logic [Width-1:0] rdata_o
);

  logic [Width-1:0] mem_q [Depth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];  // holds until the next read
      end
    end
  end

endmodule

// File: logic/stlb_miss_arbiter.sv
/*
 * miss arbiter of the shared TLB
 * ITLB / DTLB priority, set index extraction,
 * lookup context and access registers
 */
`timescale 1ns/1ps

module stlb_miss_arbiter #(
  parameter  int unsigned Depth = 16,
  localparam int unsigned IdxW  = $clog2(Depth)
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        itlb_access_i,
  input  logic                        itlb_hit_i,
  input  mmu_cfg_pkg::vaddr_t         itlb_vaddr_i,
  input  mmu_cfg_pkg::asid_t          itlb_asid_i,
  input  logic                        dtlb_access_i,
  input  logic                        dtlb_hit_i,
  input  mmu_cfg_pkg::vaddr_t         dtlb_vaddr_i,
  input  mmu_cfg_pkg::asid_t          dtlb_asid_i,
  output logic                        rd_en_o,
  output logic [IdxW-1:0]             rd_index_o,
  output tlb_types_pkg::stlb_lookup_t lookup_o,
  output logic                        access_o,
  output mmu_cfg_pkg::vaddr_t         vaddr_o
);
  import mmu_cfg_pkg::*;

  logic   itlb_sel;
  logic   dtlb_sel;
  vaddr_t req_vaddr;
  asid_t  req_asid;

  logic   valid_q;
  logic   access_q;
  logic   from_itlb_q;
  vpn_t   vpn_q;
  asid_t  asid_q;
  vaddr_t vaddr_q;

  // itlb only wins while the dtlb is idle, otherwise it retries
  assign itlb_sel = itlb_access_i & ~itlb_hit_i & ~dtlb_access_i;
  assign dtlb_sel = dtlb_access_i & ~dtlb_hit_i;

  assign req_vaddr = itlb_sel ? itlb_vaddr_i : dtlb_vaddr_i;
  assign req_asid  = itlb_sel ? itlb_asid_i : dtlb_asid_i;

  assign rd_en_o    = itlb_sel | dtlb_sel;
  assign rd_index_o = req_vaddr[PageOffsetBits +: IdxW];  // low vpn bits

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      access_q <= 1'b0;
    end else begin
      valid_q  <= rd_en_o;
      access_q <= rd_en_o;
    end
  end

  // payload, held while idle
  always_ff @(posedge clk_i) begin
    if (rd_en_o) begin
      from_itlb_q <= itlb_sel;
      vpn_q       <= req_vaddr[PageOffsetBits +: $bits(vpn_t)];
      asid_q      <= req_asid;
      vaddr_q     <= req_vaddr;
    end
  end

  assign lookup_o = '{valid: valid_q, from_itlb: from_itlb_q, vpn: vpn_q, asid: asid_q};
  assign access_o = access_q;
  assign vaddr_o  = vaddr_q;

endmodule

// File: logic/stlb_refill_ctrl.sv
/*
 * refill and flush control of the shared TLB
 * valid array, replacement way choice with LFSR,
 * RAM port arbitration and registered set valid bits
 */
`timescale 1ns/1ps

module stlb_refill_ctrl #(
  parameter  int unsigned NumWays = 4,
  parameter  int unsigned Depth   = 16,
  localparam int unsigned IdxW    = $clog2(Depth),
  localparam int unsigned WayW    = $clog2(NumWays)
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  tlb_types_pkg::tlb_update_t refill_i,
  input  logic                       rd_en_i,
  input  logic [IdxW-1:0]            rd_index_i,
  output logic [NumWays-1:0]         ram_req_o,
  output logic [NumWays-1:0]         ram_we_o,
  output logic [IdxW-1:0]            ram_addr_o,
  output logic [NumWays-1:0]         way_valid_o
);

  logic [Depth-1:0][NumWays-1:0] valid_q;
  logic [Depth-1:0][NumWays-1:0] valid_d;
  logic [NumWays-1:0]            way_valid_q;

  logic [IdxW-1:0]    wr_index;
  logic [NumWays-1:0] set_valid;  // valid bits of the refill set
  logic               all_valid;
  logic               do_refill;
  logic [WayW-1:0]    inv_way;
  logic [WayW-1:0]    rnd_way;
  logic [WayW-1:0]    repl_way;
  logic [NumWays-1:0] wr_en;

  logic [7:0] lfsr_q;
  logic [7:0] lfsr_d;
  logic       lfsr_en;

  //////////////////////////////////////////////////
  // replacement
  //////////////////////////////////////////////////
  assign wr_index  = refill_i.vpn[IdxW-1:0];
  assign set_valid = valid_q[wr_index];
  assign all_valid = &set_valid;
  assign do_refill = refill_i.valid & ~flush_i;  // flush wins

  // lowest numbered free way
  always_comb begin : find_invalid
    inv_way = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!set_valid[w]) inv_way = WayW'(w);
    end
  end

  // x^8 + x^6 + x^5 + x^4 + 1, steps only when a full set is refilled
  assign lfsr_en  = do_refill & all_valid;
  assign lfsr_d   = {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
  assign rnd_way  = lfsr_q[WayW-1:0];
  assign repl_way = all_valid ? rnd_way : inv_way;

  always_comb begin : way_onehot
    wr_en = '0;
    if (do_refill) wr_en[repl_way] = 1'b1;
  end

  always_comb begin : valid_update
    valid_d = valid_q;
    if (flush_i) begin
      valid_d = '0;
    end else begin
      valid_d[wr_index] = set_valid | wr_en;  // wr_en is zero without refill
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q     <= '0;
      lfsr_q      <= 8'hA5;  // any nonzero seed
      way_valid_q <= '0;
    end else begin
      valid_q <= valid_d;
      if (lfsr_en) lfsr_q <= lfsr_d;
      if (rd_en_i) way_valid_q <= valid_q[rd_index_i];  // in step with RAM read
    end
  end

  //////////////////////////////////////////////////
  // RAM port, write over read
  //////////////////////////////////////////////////
  assign ram_req_o   = wr_en | {NumWays{rd_en_i}};
  assign ram_we_o    = wr_en;
  assign ram_addr_o  = (|wr_en) ? wr_index : rd_index_i;
  assign way_valid_o = way_valid_q;

endmodule

// File: logic/stlb_tag_compare.sv
/*
 * tag compare of the shared TLB
 * per-way ASID and level match with superpages,
 * hit way selection and update routing
 */
`timescale 1ns/1ps

module stlb_tag_compare #(
  parameter  int unsigned NumWays = 4,
  localparam int unsigned WayW    = $clog2(NumWays)
) (
  input  tlb_types_pkg::stlb_lookup_t              lookup_i,
  input  tlb_types_pkg::stlb_tag_t [NumWays-1:0]   tag_i,
  input  tlb_types_pkg::pte_t [NumWays-1:0]        pte_i,
  input  logic [NumWays-1:0]                       way_valid_i,
  output logic                                     hit_o,
  output logic                                     itlb_miss_o,
  output logic                                     dtlb_miss_o,
  output tlb_types_pkg::tlb_update_t               itlb_update_o,
  output tlb_types_pkg::tlb_update_t               dtlb_update_o
);
  import mmu_cfg_pkg::*;
  import tlb_types_pkg::*;

  vpn_part_t [PtLevels-1:0] req_part;
  logic [NumWays-1:0]       way_hit;
  logic [WayW-1:0]          hit_way;
  logic                     any_hit;
  tlb_update_t              upd;

  assign req_part = lookup_i.vpn;  // level 0 in the low bits

  //////////////////////////////////////////////////
  // per-way match
  //////////////////////////////////////////////////
  always_comb begin : match_ways
    vpn_part_t [PtLevels-1:0] tag_part;
    logic                     asid_ok;
    logic                     level_ok;
    way_hit = '0;
    for (int w = 0; w < NumWays; w++) begin
      tag_part = tag_i[w].vpn;
      asid_ok  = (tag_i[w].asid == lookup_i.asid) || pte_i[w].g;
      level_ok = (req_part[0] == tag_part[0]);
      // a superpage flag makes all lower levels don't care
      for (int l = 1; l < PtLevels; l++) begin
        level_ok = (req_part[l] == tag_part[l]) && (tag_i[w].is_page[l-1] || level_ok);
      end
      way_hit[w] = way_valid_i[w] && asid_ok && level_ok;
    end
  end

  // lowest way wins
  always_comb begin : pick_way
    hit_way = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (way_hit[w]) hit_way = WayW'(w);
    end
  end

  assign any_hit = |way_hit;
  assign hit_o   = lookup_i.valid & any_hit;

  //////////////////////////////////////////////////
  // update towards the requesting TLB
  //////////////////////////////////////////////////
  always_comb begin : build_update
    upd.valid   = hit_o;
    upd.vpn     = lookup_i.vpn;
    upd.asid    = lookup_i.asid;
    upd.is_page = tag_i[hit_way].is_page;
    upd.content = pte_i[hit_way];
  end

  always_comb begin : route_update
    itlb_update_o       = upd;
    dtlb_update_o       = upd;
    itlb_update_o.valid = upd.valid & lookup_i.from_itlb;
    dtlb_update_o.valid = upd.valid & ~lookup_i.from_itlb;
  end

  assign itlb_miss_o = lookup_i.valid & ~any_hit & lookup_i.from_itlb;
  assign dtlb_miss_o = lookup_i.valid & ~any_hit & ~lookup_i.from_itlb;

endmodule

// File: logic/shared_tlb.sv
/*
 * shared second-level TLB, top level
 * miss arbiter, refill control, tag compare
 * and per-way tag and PTE RAMs
 */
`timescale 1ns/1ps

module shared_tlb #(
  parameter int unsigned NumWays = 4,
  parameter int unsigned Depth   = 16
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       itlb_access_i,
  input  logic                       itlb_hit_i,
  input  mmu_cfg_pkg::vaddr_t        itlb_vaddr_i,
  input  mmu_cfg_pkg::asid_t         itlb_asid_i,
  input  logic                       dtlb_access_i,
  input  logic                       dtlb_hit_i,
  input  mmu_cfg_pkg::vaddr_t        dtlb_vaddr_i,
  input  mmu_cfg_pkg::asid_t         dtlb_asid_i,
  input  tlb_types_pkg::tlb_update_t shared_tlb_update_i,
  output tlb_types_pkg::tlb_update_t itlb_update_o,
  output tlb_types_pkg::tlb_update_t dtlb_update_o,
  output logic                       itlb_miss_o,
  output logic                       dtlb_miss_o,
  output logic                       shared_tlb_access_o,
  output logic                       shared_tlb_hit_o,
  output mmu_cfg_pkg::vaddr_t        shared_tlb_vaddr_o
);
  import tlb_types_pkg::*;

  localparam int unsigned IdxW = $clog2(Depth);

  logic                    rd_en;
  logic [IdxW-1:0]         rd_index;
  stlb_lookup_t            lookup;
  logic [NumWays-1:0]      ram_req;
  logic [NumWays-1:0]      ram_we;
  logic [IdxW-1:0]         ram_addr;
  logic [NumWays-1:0]      way_valid;
  stlb_tag_t               tag_wdata;
  stlb_tag_t [NumWays-1:0] tag_rdata;
  pte_t [NumWays-1:0]      pte_rdata;

  // tag part of the refill
  assign tag_wdata = '{asid:    shared_tlb_update_i.asid,
                       vpn:     shared_tlb_update_i.vpn,
                       is_page: shared_tlb_update_i.is_page};

  stlb_miss_arbiter #(
    .Depth (Depth)
  ) i_miss_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .itlb_access_i (itlb_access_i),
    .itlb_hit_i    (itlb_hit_i),
    .itlb_vaddr_i  (itlb_vaddr_i),
    .itlb_asid_i   (itlb_asid_i),
    .dtlb_access_i (dtlb_access_i),
    .dtlb_hit_i    (dtlb_hit_i),
    .dtlb_vaddr_i  (dtlb_vaddr_i),
    .dtlb_asid_i   (dtlb_asid_i),
    .rd_en_o       (rd_en),
    .rd_index_o    (rd_index),
    .lookup_o      (lookup),
    .access_o      (shared_tlb_access_o),
    .vaddr_o       (shared_tlb_vaddr_o)
  );

  stlb_refill_ctrl #(
    .NumWays (NumWays),
    .Depth   (Depth)
  ) i_refill_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .refill_i    (shared_tlb_update_i),
    .rd_en_i     (rd_en),
    .rd_index_i  (rd_index),
    .ram_req_o   (ram_req),
    .ram_we_o    (ram_we),
    .ram_addr_o  (ram_addr),
    .way_valid_o (way_valid)
  );

  //////////////////////////////////////////////////
  // storage, one tag and one PTE RAM per way
  //////////////////////////////////////////////////
  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    stlb_ram #(
      .Width ($bits(stlb_tag_t)),
      .Depth (Depth)
    ) i_tag_ram (
      .clk_i   (clk_i),
      .req_i   (ram_req[w]),
      .we_i    (ram_we[w]),
      .addr_i  (ram_addr),
      .wdata_i (tag_wdata),
      .rdata_o (tag_rdata[w])
    );

    stlb_ram #(
      .Width ($bits(pte_t)),
      .Depth (Depth)
    ) i_pte_ram (
      .clk_i   (clk_i),
      .req_i   (ram_req[w]),
      .we_i    (ram_we[w]),
      .addr_i  (ram_addr),
      .wdata_i (shared_tlb_update_i.content),
      .rdata_o (pte_rdata[w])
    );
  end

  stlb_tag_compare #(
    .NumWays (NumWays)
  ) i_tag_compare (
    .lookup_i      (lookup),
    .tag_i         (tag_rdata),
    .pte_i         (pte_rdata),
    .way_valid_i   (way_valid),
    .hit_o         (shared_tlb_hit_o),
    .itlb_miss_o   (itlb_miss_o),
    .dtlb_miss_o   (dtlb_miss_o),
    .itlb_update_o (itlb_update_o),
    .dtlb_update_o (dtlb_update_o)
  );

endmodule

// File: dv/tb_clock_gen.sv
/*
 * testbench clock and reset source
 * free running clock, active low reset for a few cycles
 */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 4,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: dv/shared_tlb_assert.sv
/*
 * concurrent checks on the shared TLB top level
 * update exclusivity, hit against access, refill against read
 */
`timescale 1ns/1ps

module shared_tlb_assert (
  input logic clk_i,
  input logic rst_ni,
  input logic itlb_upd_valid_i,
  input logic dtlb_upd_valid_i,
  input logic access_i,
  input logic hit_i,
  input logic refill_valid_i,
  input logic rd_en_i
);

  // one first-level TLB gets the result
  update_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(itlb_upd_valid_i && dtlb_upd_valid_i))
    else $error("itlb and dtlb updates valid in the same cycle");

  hit_needs_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hit_i |-> access_i)
    else $error("hit reported without an access");

  // the single RAM port cannot serve both
  refill_no_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(refill_valid_i && rd_en_i))
    else $error("refill collided with a lookup read");

endmodule

bind shared_tlb shared_tlb_assert shared_tlb_assert_inst (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .itlb_upd_valid_i (itlb_update_o.valid),
  .dtlb_upd_valid_i (dtlb_update_o.valid),
  .access_i         (shared_tlb_access_o),
  .hit_i            (shared_tlb_hit_o),
  .refill_valid_i   (shared_tlb_update_i.valid),
  .rd_en_i          (rd_en)
);

// File: dv/shared_tlb_tb.sv
/*
 * testbench of the shared TLB
 * directed tests, compare tasks, timeout and summary
 */
`timescale 1ns/1ps

module shared_tlb_tb;
  import mmu_cfg_pkg::*;
  import tlb_types_pkg::*;

  localparam int unsigned NumWays = 4;
  localparam int unsigned Depth   = 16;
  localparam int unsigned IdxW    = $clog2(Depth);
  localparam int TestCycles       = 100;              // directed tests stay below this
  localparam int TimeoutCycles    = 20 * TestCycles;
  localparam vpn_t L0Upper        = vpn_t'((1 << VpnPartBits) - (1 << IdxW));

  logic        clk;
  logic        rst_n;
  logic        flush;
  logic        itlb_access;
  logic        itlb_hit;
  vaddr_t      itlb_vaddr;
  asid_t       itlb_asid;
  logic        dtlb_access;
  logic        dtlb_hit;
  vaddr_t      dtlb_vaddr;
  asid_t       dtlb_asid;
  tlb_update_t refill;
  tlb_update_t itlb_update;
  tlb_update_t dtlb_update;
  logic        itlb_miss;
  logic        dtlb_miss;
  logic        stlb_access;
  logic        stlb_hit;
  vaddr_t      stlb_vaddr;

  int err_cnt   = 0;
  int check_cnt = 0;
  int test_cnt  = 0;
  int cycle_cnt = 0;
  int seed      = 63652;

  tb_clock_gen #(.PeriodNs(4), .ResetCycles(8)) clock_gen_inst (.clk_o(clk), .rst_no(rst_n));

  shared_tlb #(
    .NumWays (NumWays),
    .Depth   (Depth)
  ) shared_tlb_inst (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .flush_i             (flush),
    .itlb_access_i       (itlb_access),
    .itlb_hit_i          (itlb_hit),
    .itlb_vaddr_i        (itlb_vaddr),
    .itlb_asid_i         (itlb_asid),
    .dtlb_access_i       (dtlb_access),
    .dtlb_hit_i          (dtlb_hit),
    .dtlb_vaddr_i        (dtlb_vaddr),
    .dtlb_asid_i         (dtlb_asid),
    .shared_tlb_update_i (refill),
    .itlb_update_o       (itlb_update),
    .dtlb_update_o       (dtlb_update),
    .itlb_miss_o         (itlb_miss),
    .dtlb_miss_o         (dtlb_miss),
    .shared_tlb_access_o (stlb_access),
    .shared_tlb_hit_o    (stlb_hit),
    .shared_tlb_vaddr_o  (stlb_vaddr)
  );

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////
  task automatic check_bit(input string name, input logic act, input logic exp);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, name, act, exp);
    end
  endtask

  task automatic check_update(input string name, input tlb_update_t act, input tlb_update_t exp);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, act, exp);
    end
  endtask

  task automatic check_vaddr(input string name, input vaddr_t act, input vaddr_t exp);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, act, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////
  function automatic vpn_t rand_vpn();
    return vpn_t'($random(seed));
  endfunction

  function automatic vaddr_t to_vaddr(input vpn_t vpn);
    logic [PageOffsetBits-1:0] offs;
    offs = PageOffsetBits'($random(seed));
    return {vpn, offs};
  endfunction

  function automatic pte_t make_pte(input logic is_global);
    pte_t p;
    p     = '0;
    p.ppn = ppn_t'({$random(seed), $random(seed)});
    p.d   = 1'b1;
    p.a   = 1'b1;
    p.g   = is_global;
    p.x   = 1'b1;
    p.r   = 1'b1;
    p.v   = 1'b1;
    return p;
  endfunction

  // one-cycle walker refill, returns on the next falling edge
  task automatic do_refill(input vpn_t vpn, input asid_t asid, input is_page_t pg,
                           input pte_t pte);
    refill.valid   = 1'b1;
    refill.vpn     = vpn;
    refill.asid    = asid;
    refill.is_page = pg;
    refill.content = pte;
    @(negedge clk);
    refill.valid = 1'b0;
  endtask

  task automatic do_flush();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
  endtask

  // returns in the cycle that shows the lookup result
  task automatic do_lookup(input logic from_itlb, input vaddr_t va, input asid_t asid);
    if (from_itlb) begin
      itlb_access = 1'b1;
      itlb_vaddr  = va;
      itlb_asid   = asid;
    end else begin
      dtlb_access = 1'b1;
      dtlb_vaddr  = va;
      dtlb_asid   = asid;
    end
    @(negedge clk);
    itlb_access = 1'b0;
    dtlb_access = 1'b0;
  endtask

  task automatic expect_hit(input logic from_itlb, input vaddr_t va, input asid_t asid,
                            input is_page_t pg, input pte_t pte);
    tlb_update_t exp;
    exp.valid   = 1'b1;
    exp.vpn     = va[PageOffsetBits +: VpnBits];  // request vpn, not the stored one
    exp.asid    = asid;
    exp.is_page = pg;
    exp.content = pte;
    check_bit("shared_tlb_access_o", stlb_access, 1'b1);
    check_bit("shared_tlb_hit_o", stlb_hit, 1'b1);
    check_vaddr("shared_tlb_vaddr_o", stlb_vaddr, va);
    check_bit("itlb_miss_o", itlb_miss, 1'b0);
    check_bit("dtlb_miss_o", dtlb_miss, 1'b0);
    if (from_itlb) begin
      check_update("itlb_update_o", itlb_update, exp);
      check_bit("dtlb_update_o.valid", dtlb_update.valid, 1'b0);
    end else begin
      check_update("dtlb_update_o", dtlb_update, exp);
      check_bit("itlb_update_o.valid", itlb_update.valid, 1'b0);
    end
  endtask

  task automatic expect_miss(input logic from_itlb, input vaddr_t va);
    check_bit("shared_tlb_access_o", stlb_access, 1'b1);
    check_bit("shared_tlb_hit_o", stlb_hit, 1'b0);
    check_vaddr("shared_tlb_vaddr_o", stlb_vaddr, va);
    check_bit("itlb_miss_o", itlb_miss, from_itlb);
    check_bit("dtlb_miss_o", dtlb_miss, ~from_itlb);
    check_bit("itlb_update_o.valid", itlb_update.valid, 1'b0);
    check_bit("dtlb_update_o.valid", dtlb_update.valid, 1'b0);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, err_cnt - errs_before);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////
  task automatic reset_miss_test();
    int     errs;
    vaddr_t va;
    errs = err_cnt;
    check_bit("shared_tlb_access_o", stlb_access, 1'b0);
    check_bit("itlb_update_o.valid", itlb_update.valid, 1'b0);
    check_bit("dtlb_update_o.valid", dtlb_update.valid, 1'b0);
    va = to_vaddr(rand_vpn());
    do_lookup(1'b1, va, asid_t'($random(seed)));
    expect_miss(1'b1, va);
    finish_test("reset miss", errs);
  endtask

  task automatic refill_hit_test();
    int     errs;
    logic   side;
    vpn_t   vpn;
    asid_t  asid;
    pte_t   pte;
    vaddr_t va;
    errs = err_cnt;
    for (int s = 0; s < 2; s++) begin
      side = (s == 0);  // itlb first, then dtlb
      vpn  = rand_vpn();
      asid = asid_t'($random(seed));
      pte  = make_pte(1'b0);
      va   = to_vaddr(vpn);
      do_refill(vpn, asid, 2'b00, pte);
      do_lookup(side, va, asid);
      expect_hit(side, va, asid, 2'b00, pte);
    end
    finish_test("refill hit", errs);
  endtask

  task automatic asid_test();
    int     errs;
    vpn_t   vpn;
    asid_t  asid;
    pte_t   pte;
    vaddr_t va;
    errs = err_cnt;
    asid = asid_t'($random(seed));
    vpn  = rand_vpn();
    va   = to_vaddr(vpn);
    do_refill(vpn, asid, 2'b00, make_pte(1'b0));
    do_lookup(1'b0, va, ~asid);
    expect_miss(1'b0, va);
    vpn = rand_vpn();  // global entry, any asid
    va  = to_vaddr(vpn);
    pte = make_pte(1'b1);
    do_refill(vpn, asid, 2'b00, pte);
    do_lookup(1'b0, va, ~asid);
    expect_hit(1'b0, va, ~asid, 2'b00, pte);
    finish_test("asid and global", errs);
  endtask

  task automatic superpage_test();
    int     errs;
    vpn_t   vpn;
    asid_t  asid;
    pte_t   pte;
    vaddr_t va;
    errs = err_cnt;
    asid = asid_t'($random(seed));
    vpn  = rand_vpn();
    pte  = make_pte(1'b0);
    do_refill(vpn, asid, 2'b01, pte);
    va = to_vaddr(vpn ^ L0Upper);
    do_lookup(1'b1, va, asid);
    expect_hit(1'b1, va, asid, 2'b01, pte);
    vpn = rand_vpn();  // same offset pattern on a 4 KiB page
    do_refill(vpn, asid, 2'b00, make_pte(1'b0));
    va = to_vaddr(vpn ^ L0Upper);
    do_lookup(1'b1, va, asid);
    expect_miss(1'b1, va);
    finish_test("2 MiB superpage", errs);
  endtask

  task automatic both_miss_test();
    int     errs;
    asid_t  asid;
    vpn_t   ivpn;
    vpn_t   dvpn;
    pte_t   dpte;
    vaddr_t dva;
    errs = err_cnt;
    asid = asid_t'($random(seed));
    ivpn = rand_vpn();
    dvpn = rand_vpn();
    dpte = make_pte(1'b0);
    do_refill(ivpn, asid, 2'b00, make_pte(1'b0));
    do_refill(dvpn, asid, 2'b00, dpte);
    dva         = to_vaddr(dvpn);
    itlb_access = 1'b1;
    itlb_vaddr  = to_vaddr(ivpn);
    itlb_asid   = asid;
    dtlb_access = 1'b1;
    dtlb_vaddr  = dva;
    dtlb_asid   = asid;
    @(negedge clk);
    itlb_access = 1'b0;
    dtlb_access = 1'b0;
    expect_hit(1'b0, dva, asid, 2'b00, dpte);
    @(negedge clk);
    check_bit("shared_tlb_access_o", stlb_access, 1'b0);  // itlb request dropped
    finish_test("simultaneous misses", errs);
  endtask

  task automatic replacement_test();
    int     errs;
    int     hits;
    vpn_t   base;
    asid_t  asid;
    vaddr_t va;
    vpn_t   vpns [NumWays+1];
    pte_t   ptes [NumWays+1];
    errs = err_cnt;
    do_flush();
    base = rand_vpn();
    asid = asid_t'($random(seed));
    for (int k = 0; k <= NumWays; k++) begin
      vpns[k] = base ^ (vpn_t'(k + 1) << IdxW);  // same set, distinct tags
      ptes[k] = make_pte(1'b0);
    end
    for (int k = 0; k < NumWays; k++) do_refill(vpns[k], asid, 2'b00, ptes[k]);
    for (int k = 0; k < NumWays; k++) begin
      va = to_vaddr(vpns[k]);
      do_lookup(1'b0, va, asid);
      expect_hit(1'b0, va, asid, 2'b00, ptes[k]);
    end
    do_refill(vpns[NumWays], asid, 2'b00, ptes[NumWays]);
    va = to_vaddr(vpns[NumWays]);
    do_lookup(1'b0, va, asid);
    expect_hit(1'b0, va, asid, 2'b00, ptes[NumWays]);
    hits = 0;
    for (int k = 0; k <= NumWays; k++) begin
      va = to_vaddr(vpns[k]);
      do_lookup(1'b0, va, asid);
      if (stlb_hit === 1'b1) begin
        hits++;
        expect_hit(1'b0, va, asid, 2'b00, ptes[k]);
      end
    end
    if (hits != NumWays) begin
      err_cnt++;
      $display("replacement left %0d of %0d entries resident, expected %0d",
               hits, NumWays + 1, NumWays);
    end
    do_flush();
    for (int k = 0; k <= NumWays; k++) begin
      va = to_vaddr(vpns[k]);
      do_lookup(1'b0, va, asid);
      expect_miss(1'b0, va);
    end
    finish_test("set replacement and flush", errs);
  endtask

  //////////////////////////////////////////////////
  // sequence, timeout and summary
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("timeout after %0d cycles, tests did not complete", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    flush       = 1'b0;
    itlb_access = 1'b0;
    itlb_hit    = 1'b0;
    itlb_vaddr  = '0;
    itlb_asid   = '0;
    dtlb_access = 1'b0;
    dtlb_hit    = 1'b0;
    dtlb_vaddr  = '0;
    dtlb_asid   = '0;
    refill      = '0;
    wait (rst_n === 1'b1);
    @(negedge clk);
    reset_miss_test();
    refill_hit_test();
    asid_test();
    superpage_test();
    both_miss_test();
    replacement_test();
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: files.f
logic/mmu_cfg_pkg.sv
logic/tlb_types_pkg.sv
logic/stlb_ram.sv
logic/stlb_miss_arbiter.sv
logic/stlb_refill_ctrl.sv
logic/stlb_tag_compare.sv
logic/shared_tlb.sv
dv/tb_clock_gen.sv
dv/shared_tlb_assert.sv
dv/shared_tlb_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the shared TLB testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module shared_tlb_tb -f files.f -o shared_tlb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/shared_tlb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0
